/* common/mmu_pkg.sv */
`default_nettype none

package mmu_pkg;

    // -------------------------------------------------------------------------
    // address widths
    // -------------------------------------------------------------------------
    parameter int unsigned PAGE_OFFSET_W = 12;
    parameter int unsigned PTE_BYTES     = 4;

    typedef logic [31:0] vaddr_t;
    typedef logic [33:0] paddr_t;
    typedef logic [21:0] ppn_t;
    // vpn[1] in the upper ten bits, vpn[0] in the lower ten
    typedef logic [19:0] vpn_t;

    // trap causes of the load/store side
    parameter logic [31:0] CAUSE_LOAD_PAGE_FAULT  = 32'd13;
    parameter logic [31:0] CAUSE_STORE_PAGE_FAULT = 32'd15;

    // riscv privilege encodings, 2'b10 is reserved
    typedef enum logic [1:0] {
        PRIV_LVL_U = 2'b00,
        PRIV_LVL_S = 2'b01,
        PRIV_LVL_M = 2'b11
    } priv_lvl_t;

    // -------------------------------------------------------------------------
    // page table entry and tlb refill
    // -------------------------------------------------------------------------
    typedef struct packed {
        ppn_t       ppn;
        logic [1:0] rsw;
        logic       d;
        logic       a;
        logic       g;
        logic       u;
        logic       x;
        logic       w;
        logic       r;
        logic       v;
    } pte_t;

    typedef struct packed {
        logic valid;
        logic is_4m;
        vpn_t vpn;
        pte_t pte;
    } tlb_update_t;

    // -------------------------------------------------------------------------
    // load/store side
    // -------------------------------------------------------------------------
    typedef struct packed {
        vaddr_t vaddr;
        logic   is_store;
    } lsu_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] cause;
        logic [31:0] tval;
    } exception_t;

    typedef struct packed {
        paddr_t     paddr;
        exception_t exception;
    } lsu_resp_t;

    // -------------------------------------------------------------------------
    // walker handshake and apb page table port
    // -------------------------------------------------------------------------
    typedef struct packed {
        logic   valid;
        vaddr_t vaddr;
    } walk_req_t;

    typedef struct packed {
        logic   active;
        logic   error;
        vaddr_t fault_vaddr;
    } ptw_status_t;

    typedef struct packed {
        logic   psel;
        logic   penable;
        paddr_t paddr;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
    } apb_resp_t;

endpackage

`default_nettype wire

/* dtlb/dtlb.sv */
`timescale 1ns/1ps
`default_nettype none

module dtlb #(
    parameter int unsigned TLB_ENTRIES = 4
) (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 flush_i,
    input  mmu_pkg::tlb_update_t update_i,
    input  mmu_pkg::vaddr_t      lu_vaddr_i,
    output logic                 lu_hit_o,
    output mmu_pkg::pte_t        lu_pte_o,
    output logic                 lu_is_4m_o
);

    // index width, kept at one bit for a single entry
    localparam int unsigned IDX_W = (TLB_ENTRIES > 1) ? $clog2(TLB_ENTRIES) : 1;

    logic [TLB_ENTRIES-1:0] valid_q;
    mmu_pkg::vpn_t          tag_q   [TLB_ENTRIES];
    logic                   is_4m_q [TLB_ENTRIES];
    mmu_pkg::pte_t          pte_q   [TLB_ENTRIES];
    logic [IDX_W-1:0]       victim_q;
    logic [IDX_W-1:0]       wr_idx;
    logic                   found_free;
    mmu_pkg::vpn_t          lu_vpn;

    assign lu_vpn = lu_vaddr_i[31:mmu_pkg::PAGE_OFFSET_W];

    // -------------------------------------------------------------------------
    // lookup
    // -------------------------------------------------------------------------
    // fully associative compare over all entries
    // megapage entries ignore vpn[0]
    always_comb begin
        lu_hit_o   = 1'b0;
        lu_pte_o   = '0;
        lu_is_4m_o = 1'b0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (valid_q[i] && (tag_q[i][19:10] == lu_vpn[19:10]) &&
                (is_4m_q[i] || (tag_q[i][9:0] == lu_vpn[9:0]))) begin
                lu_hit_o   = 1'b1;
                lu_pte_o   = pte_q[i];
                lu_is_4m_o = is_4m_q[i];
            end
        end
    end

    // -------------------------------------------------------------------------
    // refill slot selection
    // -------------------------------------------------------------------------
    // lowest invalid entry wins, otherwise the round-robin victim
    always_comb begin
        found_free = 1'b0;
        wr_idx     = victim_q;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                found_free = 1'b1;
                wr_idx     = IDX_W'(i);
            end
        end
    end

    // valid bits and victim pointer
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q  <= '0;
            victim_q <= '0;
        end else if (flush_i) begin
            // global flush drops every mapping
            valid_q <= '0;
        end else if (update_i.valid) begin
            valid_q[wr_idx] <= 1'b1;
            // pointer only advances when an entry was evicted
            if (!found_free) begin
                if (victim_q == IDX_W'(TLB_ENTRIES - 1)) begin
                    victim_q <= '0;
                end else begin
                    victim_q <= victim_q + IDX_W'(1);
                end
            end
        end
    end

    // tag and pte storage
    always_ff @(posedge clk_i) begin
        if (update_i.valid) begin
            tag_q[wr_idx]   <= update_i.vpn;
            is_4m_q[wr_idx] <= update_i.is_4m;
            pte_q[wr_idx]   <= update_i.pte;
        end
    end

endmodule

`default_nettype wire

/* logic/lsu_translate.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_translate (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 en_translation_i,
    input  logic                 lsu_req_i,
    input  mmu_pkg::lsu_req_t    lsu_req_data_i,
    input  mmu_pkg::priv_lvl_t   priv_lvl_i,
    input  logic                 sum_i,
    input  logic                 mxr_i,
    input  logic                 lu_hit_i,
    input  mmu_pkg::pte_t        lu_pte_i,
    input  logic                 lu_is_4m_i,
    input  mmu_pkg::ptw_status_t walk_status_i,
    output mmu_pkg::vaddr_t      lu_vaddr_o,
    output mmu_pkg::walk_req_t   walk_req_o,
    output logic                 lsu_valid_o,
    output mmu_pkg::lsu_resp_t   lsu_resp_o,
    output logic                 lsu_dtlb_hit_o,
    output logic                 dtlb_miss_o
);

    logic            req_q;
    logic            hit_q;
    mmu_pkg::vaddr_t vaddr_q;
    logic            is_store_q;
    mmu_pkg::pte_t   pte_q;
    logic            is_4m_q;
    logic            priv_err;
    logic            perm_fault;
    logic [31:0]     fault_cause;

    // -------------------------------------------------------------------------
    // cycle 0: lookup and walk request
    // -------------------------------------------------------------------------
    assign lu_vaddr_o = lsu_req_data_i.vaddr;

    // pass-through counts as a hit
    assign lsu_dtlb_hit_o = lsu_req_i && (lu_hit_i || !en_translation_i);

    // no new walk once the response is out
    assign walk_req_o.valid = lsu_req_i && en_translation_i && !lu_hit_i && !lsu_valid_o;
    assign walk_req_o.vaddr = lsu_req_data_i.vaddr;

    // counted once per walk, while the walker is still idle
    assign dtlb_miss_o = walk_req_o.valid && !walk_status_i.active;

    // stage the request, a held request is not seen again after valid
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            req_q <= 1'b0;
            hit_q <= 1'b0;
        end else begin
            req_q <= lsu_req_i && !lsu_valid_o;
            hit_q <= lu_hit_i;
        end
    end

    always_ff @(posedge clk_i) begin
        vaddr_q    <= lsu_req_data_i.vaddr;
        is_store_q <= lsu_req_data_i.is_store;
        pte_q      <= lu_pte_i;
        is_4m_q    <= lu_is_4m_i;
    end

    // -------------------------------------------------------------------------
    // cycle 1: permission checks
    // -------------------------------------------------------------------------
    // user page from s mode needs sum, u mode needs a user page
    assign priv_err = ((priv_lvl_i == mmu_pkg::PRIV_LVL_S) && !sum_i && pte_q.u) ||
                      ((priv_lvl_i == mmu_pkg::PRIV_LVL_U) && !pte_q.u);

    // store needs w and d, load needs r or x with mxr
    assign perm_fault = is_store_q ? (priv_err || !pte_q.w || !pte_q.d)
                                   : (priv_err || !(pte_q.r || (mxr_i && pte_q.x)));

    assign fault_cause = is_store_q ? mmu_pkg::CAUSE_STORE_PAGE_FAULT
                                    : mmu_pkg::CAUSE_LOAD_PAGE_FAULT;

    always_comb begin
        lsu_valid_o          = 1'b0;
        lsu_resp_o.exception = '0;
        if (!en_translation_i) begin
            // bare mode, zero extended
            lsu_resp_o.paddr = mmu_pkg::paddr_t'(vaddr_q);
            lsu_valid_o      = req_q;
        end else begin
            if (is_4m_q) begin
                lsu_resp_o.paddr = {pte_q.ppn[21:10], vaddr_q[21:0]};
            end else begin
                lsu_resp_o.paddr = {pte_q.ppn, vaddr_q[mmu_pkg::PAGE_OFFSET_W-1:0]};
            end
            if (req_q && hit_q) begin
                lsu_valid_o = 1'b1;
                if (perm_fault) begin
                    lsu_resp_o.exception.valid = 1'b1;
                    lsu_resp_o.exception.cause = fault_cause;
                    lsu_resp_o.exception.tval  = vaddr_q;
                end
            end else if (req_q && walk_status_i.error) begin
                // walker fault answered in its own cycle
                lsu_valid_o                = 1'b1;
                lsu_resp_o.exception.valid = 1'b1;
                lsu_resp_o.exception.cause = fault_cause;
                lsu_resp_o.exception.tval  = walk_status_i.fault_vaddr;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/mmu_sv32.sv */
`timescale 1ns/1ps
`default_nettype none

module mmu_sv32 #(
    parameter int unsigned TLB_ENTRIES = 4
) (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                en_translation_i,
    input  logic                flush_tlb_i,
    input  logic                lsu_req_i,
    input  mmu_pkg::lsu_req_t   lsu_req_data_i,
    input  mmu_pkg::priv_lvl_t  priv_lvl_i,
    input  logic                sum_i,
    input  logic                mxr_i,
    input  mmu_pkg::ppn_t       satp_ppn_i,
    input  mmu_pkg::apb_resp_t  apb_resp_i,
    output logic                lsu_valid_o,
    output mmu_pkg::lsu_resp_t  lsu_resp_o,
    output logic                lsu_dtlb_hit_o,
    output logic                dtlb_miss_o,
    output mmu_pkg::apb_req_t   apb_req_o
);

    // lookup path between check stage and tlb
    mmu_pkg::vaddr_t      lu_vaddr;
    logic                 lu_hit;
    mmu_pkg::pte_t        lu_pte;
    logic                 lu_is_4m;
    // miss handling
    mmu_pkg::walk_req_t   walk_req;
    mmu_pkg::ptw_status_t walk_status;
    mmu_pkg::tlb_update_t tlb_update;

    dtlb #(
        .TLB_ENTRIES(TLB_ENTRIES)
    ) u_dtlb (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .flush_i    (flush_tlb_i),
        .update_i   (tlb_update),
        .lu_vaddr_i (lu_vaddr),
        .lu_hit_o   (lu_hit),
        .lu_pte_o   (lu_pte),
        .lu_is_4m_o (lu_is_4m)
    );

    ptw u_ptw (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .walk_req_i    (walk_req),
        .satp_ppn_i    (satp_ppn_i),
        .apb_resp_i    (apb_resp_i),
        .walk_status_o (walk_status),
        .tlb_update_o  (tlb_update),
        .apb_req_o     (apb_req_o)
    );

    lsu_translate u_lsu_translate (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .en_translation_i (en_translation_i),
        .lsu_req_i        (lsu_req_i),
        .lsu_req_data_i   (lsu_req_data_i),
        .priv_lvl_i       (priv_lvl_i),
        .sum_i            (sum_i),
        .mxr_i            (mxr_i),
        .lu_hit_i         (lu_hit),
        .lu_pte_i         (lu_pte),
        .lu_is_4m_i       (lu_is_4m),
        .walk_status_i    (walk_status),
        .lu_vaddr_o       (lu_vaddr),
        .walk_req_o       (walk_req),
        .lsu_valid_o      (lsu_valid_o),
        .lsu_resp_o       (lsu_resp_o),
        .lsu_dtlb_hit_o   (lsu_dtlb_hit_o),
        .dtlb_miss_o      (dtlb_miss_o)
    );

endmodule

`default_nettype wire

/* ptw/ptw.sv */
`timescale 1ns/1ps
`default_nettype none

module ptw (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  mmu_pkg::walk_req_t   walk_req_i,
    input  mmu_pkg::ppn_t        satp_ppn_i,
    input  mmu_pkg::apb_resp_t   apb_resp_i,
    output mmu_pkg::ptw_status_t walk_status_o,
    output mmu_pkg::tlb_update_t tlb_update_o,
    output mmu_pkg::apb_req_t    apb_req_o
);

    typedef enum logic [1:0] {
        PTW_IDLE,
        PTW_LVL1,
        PTW_LVL0,
        PTW_ERROR
    } ptw_state_t;

    ptw_state_t       state_q;
    ptw_state_t       state_d;
    logic             penable_q;
    logic             penable_d;
    mmu_pkg::paddr_t  paddr_q;
    mmu_pkg::paddr_t  paddr_d;
    mmu_pkg::vaddr_t  vaddr_q;
    mmu_pkg::pte_t    pte;
    logic             is_leaf;
    logic             pte_bad;
    logic             sp_misaligned;

    // pte address: table base plus index scaled by the pte size
    function automatic mmu_pkg::paddr_t pte_addr(input mmu_pkg::ppn_t base,
                                                 input logic [9:0] idx);
        mmu_pkg::paddr_t offs;
        offs = mmu_pkg::paddr_t'(idx) * mmu_pkg::paddr_t'(mmu_pkg::PTE_BYTES);
        return (mmu_pkg::paddr_t'(base) << mmu_pkg::PAGE_OFFSET_W) + offs;
    endfunction

    // -------------------------------------------------------------------------
    // pte decode
    // -------------------------------------------------------------------------
    assign pte     = mmu_pkg::pte_t'(apb_resp_i.prdata);
    assign is_leaf = pte.r || pte.x;
    // w without r is reserved, accessed bit only matters on a leaf
    assign pte_bad = !pte.v || (pte.w && !pte.r) || (is_leaf && !pte.a);
    // a megapage must sit on a 4 MiB boundary
    assign sp_misaligned = (state_q == PTW_LVL1) && is_leaf && (pte.ppn[9:0] != '0);

    // -------------------------------------------------------------------------
    // walk fsm
    // -------------------------------------------------------------------------
    always_comb begin
        state_d            = state_q;
        penable_d          = penable_q;
        paddr_d            = paddr_q;
        tlb_update_o       = '0;
        tlb_update_o.vpn   = vaddr_q[31:mmu_pkg::PAGE_OFFSET_W];
        tlb_update_o.pte   = pte;
        tlb_update_o.is_4m = (state_q == PTW_LVL1);
        case (state_q)
            PTW_IDLE: begin
                if (walk_req_i.valid) begin
                    state_d = PTW_LVL1;
                    paddr_d = pte_addr(satp_ppn_i, walk_req_i.vaddr[31:22]);
                end
            end
            PTW_LVL1,
            PTW_LVL0: begin
                if (!penable_q) begin
                    // setup phase done, move to access
                    penable_d = 1'b1;
                end else if (apb_resp_i.pready) begin
                    penable_d = 1'b0;
                    if (pte_bad || sp_misaligned) begin
                        state_d = PTW_ERROR;
                    end else if (is_leaf) begin
                        // refill lands in the tlb at this edge
                        state_d            = PTW_IDLE;
                        tlb_update_o.valid = 1'b1;
                    end else if (state_q == PTW_LVL1) begin
                        // pointer to the second level table
                        state_d = PTW_LVL0;
                        paddr_d = pte_addr(pte.ppn, vaddr_q[21:12]);
                    end else begin
                        // no third level in sv32
                        state_d = PTW_ERROR;
                    end
                end
            end
            PTW_ERROR: begin
                state_d = PTW_IDLE;
            end
            default: begin
                state_d = PTW_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q   <= PTW_IDLE;
            penable_q <= 1'b0;
        end else begin
            state_q   <= state_d;
            penable_q <= penable_d;
        end
    end

    // walk address and pte pointer
    always_ff @(posedge clk_i) begin
        if ((state_q == PTW_IDLE) && walk_req_i.valid) begin
            vaddr_q <= walk_req_i.vaddr;
        end
        paddr_q <= paddr_d;
    end

    // -------------------------------------------------------------------------
    // outputs
    // -------------------------------------------------------------------------
    assign apb_req_o.psel    = (state_q == PTW_LVL1) || (state_q == PTW_LVL0);
    assign apb_req_o.penable = penable_q;
    assign apb_req_o.paddr   = paddr_q;

    // error state lasts one cycle and is the fault pulse
    assign walk_status_o.active      = (state_q != PTW_IDLE);
    assign walk_status_o.error       = (state_q == PTW_ERROR);
    assign walk_status_o.fault_vaddr = vaddr_q;

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module tb_mmu

if ./obj_dir/Vtb_mmu +verilator+error+limit+1000 | tee /dev/stderr | grep -qF '** PASS **'; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* testbench/mmu_props.sv */
`timescale 1ns/1ps
`default_nettype none

module mmu_props (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  mmu_pkg::apb_req_t  apb_req_i,
    input  mmu_pkg::apb_resp_t apb_resp_i,
    input  logic               lsu_valid_i
);

    // number of failed properties, read by the testbench at the end
    int unsigned fail_cnt = 0;

    // -------------------------------------------------------------------------
    // apb page table port
    // -------------------------------------------------------------------------
    // access phase only inside a selected transfer
    penable_needs_psel: assert property (@(posedge clk_i) disable iff (!rst_ni)
        apb_req_i.penable |-> apb_req_i.psel)
    else begin
        fail_cnt++;
        $error("apb penable high while psel is low");
    end

    // setup phase lasts exactly one cycle
    setup_then_access: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $rose(apb_req_i.psel) |=> apb_req_i.penable)
    else begin
        fail_cnt++;
        $error("apb setup phase not followed by the access phase");
    end

    // address held while the completer stalls
    paddr_stable_in_wait: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (apb_req_i.psel && apb_req_i.penable && !apb_resp_i.pready) |=>
        $stable(apb_req_i.paddr))
    else begin
        fail_cnt++;
        $error("apb paddr changed during a stalled access");
    end

    // -------------------------------------------------------------------------
    // load/store side
    // -------------------------------------------------------------------------
    valid_low_after_reset: assert property (@(posedge clk_i)
        $rose(rst_ni) |-> !lsu_valid_i)
    else begin
        fail_cnt++;
        $error("lsu_valid_o high in the first cycle after reset");
    end

endmodule

bind mmu_sv32 mmu_props u_mmu_props (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .apb_req_i   (apb_req_o),
    .apb_resp_i  (apb_resp_i),
    .lsu_valid_i (lsu_valid_o)
);

`default_nettype wire

/* testbench/tb_mmu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mmu;

    localparam int TIMEOUT_CYCLES = 200;
    // how the page table port must behave during one access
    localparam int WALK_ANY = 0;
    localparam int WALK_YES = 1;
    localparam int WALK_NO  = 2;
    // root table at page 0x10 with the single level-0 table right after it
    localparam mmu_pkg::ppn_t   ROOT_PPN = 22'h00010;
    localparam mmu_pkg::paddr_t PT_BASE  = 34'h0_0001_0000;
    // pte flag bits d a g u x w r v from the top
    localparam logic [7:0] F_V = 8'h01;
    localparam logic [7:0] F_R = 8'h02;
    localparam logic [7:0] F_W = 8'h04;
    localparam logic [7:0] F_X = 8'h08;
    localparam logic [7:0] F_U = 8'h10;
    localparam logic [7:0] F_A = 8'h40;
    localparam logic [7:0] F_D = 8'h80;
    localparam logic [7:0] F_RWAD = F_V | F_R | F_W | F_A | F_D;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 translation_on;
    logic                 flush;
    logic                 lsu_req;
    mmu_pkg::lsu_req_t    lsu_req_data;
    mmu_pkg::priv_lvl_t   priv_lvl;
    logic                 sum;
    logic                 mxr;
    mmu_pkg::ppn_t        satp_ppn;
    mmu_pkg::apb_resp_t   apb_resp = '0;
    logic                 lsu_valid;
    mmu_pkg::lsu_resp_t   lsu_resp;
    logic                 lsu_dtlb_hit;
    logic                 dtlb_miss;
    mmu_pkg::apb_req_t    apb_req;

    logic [31:0] pt_mem [0:2047];
    integer      seed = 32'h25dfe2a2;
    int unsigned draw;
    int unsigned wait_left;
    int          n_tests = 0;
    int          n_failed = 0;
    int          n_errors = 0;
    logic        timed_out = 1'b0;

    always #10 clk = ~clk;

    mmu_sv32 #(
        .TLB_ENTRIES(2)
    ) u_mmu_sv32 (
        .clk_i            (clk),
        .rst_ni           (rst_n),
        .en_translation_i (translation_on),
        .flush_tlb_i      (flush),
        .lsu_req_i        (lsu_req),
        .lsu_req_data_i   (lsu_req_data),
        .priv_lvl_i       (priv_lvl),
        .sum_i            (sum),
        .mxr_i            (mxr),
        .satp_ppn_i       (satp_ppn),
        .apb_resp_i       (apb_resp),
        .lsu_valid_o      (lsu_valid),
        .lsu_resp_o       (lsu_resp),
        .lsu_dtlb_hit_o   (lsu_dtlb_hit),
        .dtlb_miss_o      (dtlb_miss),
        .apb_req_o        (apb_req)
    );

    function automatic logic [31:0] make_pte(input mmu_pkg::ppn_t ppn, input logic [7:0] flags);
        return {ppn, 2'b00, flags};
    endfunction

    // words outside the two table pages read as zero
    function automatic logic [31:0] pt_read(input mmu_pkg::paddr_t addr);
        mmu_pkg::paddr_t offs;
        logic [31:0]     word;
        offs = addr - PT_BASE;
        word = 32'h0;
        if (addr >= PT_BASE && offs < 34'h2000) begin
            word = pt_mem[offs[12:2]];
        end
        return word;
    endfunction

    // -------------------------------------------------------------------------
    // apb page table memory with 0 to 2 random wait states per read
    // -------------------------------------------------------------------------
    always @(posedge clk) begin
        if (!rst_n) begin
            apb_resp  <= '0;
            wait_left <= 0;
        end else if (apb_req.psel && !apb_req.penable) begin
            // data is ready from the setup phase on
            draw = $unsigned($random(seed)) % 32'd3;
            wait_left       <= draw;
            apb_resp.pready <= (draw == 0);
            apb_resp.prdata <= pt_read(apb_req.paddr);
        end else if (apb_req.psel && apb_req.penable && !apb_resp.pready) begin
            wait_left       <= wait_left - 1;
            apb_resp.pready <= (wait_left == 1);
        end else begin
            apb_resp.pready <= 1'b0;
        end
    end

    task automatic fill_tables;
        // invalid filler with v clear everywhere
        for (int i = 0; i < 2048; i++) begin
            pt_mem[i] = (32'(i) * 32'h0001_0003) & 32'hffff_fffe;
        end
        // root table holds a pointer plus an aligned and a misaligned megapage
        pt_mem[1] = make_pte(22'h00011, F_V);
        pt_mem[2] = make_pte(22'h00400, F_RWAD);
        pt_mem[3] = make_pte(22'h00401, F_V | F_R | F_A);
        // level 0 table for vaddr 0x0040_k000
        pt_mem[1024] = make_pte(22'h12345, F_RWAD);
        pt_mem[1025] = make_pte(22'h12346, F_V | F_R | F_A | F_D);
        pt_mem[1026] = make_pte(22'h12347, F_V | F_R | F_W | F_A);
        pt_mem[1027] = make_pte(22'h23456, F_RWAD | F_U);
        pt_mem[1028] = make_pte(22'h12348, F_V | F_X | F_A);
        pt_mem[1029] = make_pte(22'h12349, F_R | F_W | F_A | F_D);
        pt_mem[1030] = make_pte(22'h1234a, F_V | F_R | F_W | F_D);
        pt_mem[1031] = make_pte(22'h3aaaa, F_RWAD);
        pt_mem[1032] = make_pte(22'h3bbbb, F_RWAD);
    endtask

    task automatic set_mode(input logic en, input mmu_pkg::priv_lvl_t priv,
                            input logic sum_set, input logic mxr_set);
        @(posedge clk);
        translation_on <= en;
        priv_lvl       <= priv;
        sum            <= sum_set;
        mxr            <= mxr_set;
    endtask

    task automatic flush_tlb;
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
    endtask

    task automatic compare_field(input string test, input string field,
                                 input logic [33:0] got, input logic [33:0] exp);
        assert (got === exp) else begin
            $display("ERROR %s: %s got %h expected %h", test, field, got, exp);
            n_errors++;
        end
    endtask

    // -------------------------------------------------------------------------
    // one load or store held until lsu_valid_o
    // -------------------------------------------------------------------------
    task automatic run_access(input string name, input mmu_pkg::vaddr_t va, input logic st,
                              input logic exp_fault, input mmu_pkg::paddr_t exp_pa,
                              input int walk_mode);
        int                 cycles;
        int                 errors_before;
        int                 misses;
        logic               done;
        logic               psel_seen;
        logic               hit_seen;
        logic [31:0]        exp_cause;
        mmu_pkg::lsu_resp_t resp;
        if (!timed_out) begin
            errors_before = n_errors;
            exp_cause = st ? 32'd15 : 32'd13;
            cycles    = 0;
            misses    = 0;
            done      = 1'b0;
            psel_seen = 1'b0;
            hit_seen  = 1'b0;
            resp      = '0;
            n_tests++;
            @(posedge clk);
            lsu_req               <= 1'b1;
            lsu_req_data.vaddr    <= va;
            lsu_req_data.is_store <= st;
            // outputs sampled mid-cycle
            while (!done && cycles < TIMEOUT_CYCLES) begin
                @(negedge clk);
                cycles++;
                psel_seen = psel_seen | apb_req.psel;
                hit_seen  = hit_seen | lsu_dtlb_hit;
                if (dtlb_miss) begin
                    misses++;
                end
                if (lsu_valid) begin
                    done = 1'b1;
                    resp = lsu_resp;
                end
            end
            @(posedge clk);
            lsu_req <= 1'b0;
            if (!done) begin
                $display("test %s: timed out waiting for lsu_valid_o", name);
                timed_out = 1'b1;
                n_failed++;
            end else begin
                compare_field(name, "lsu_resp_o.exception.valid",
                              34'(resp.exception.valid), 34'(exp_fault));
                if (exp_fault) begin
                    compare_field(name, "lsu_resp_o.exception.cause",
                                  34'(resp.exception.cause), 34'(exp_cause));
                    compare_field(name, "lsu_resp_o.exception.tval",
                                  34'(resp.exception.tval), 34'(va));
                end else begin
                    compare_field(name, "lsu_resp_o.paddr", resp.paddr, exp_pa);
                end
                if (walk_mode == WALK_YES) begin
                    assert (psel_seen) else begin
                        $display("test %s: no page table read was seen", name);
                        n_errors++;
                    end
                    // exactly one miss pulse starts the walk
                    compare_field(name, "dtlb_miss_o pulses", 34'(misses), 34'd1);
                end else if (walk_mode == WALK_NO) begin
                    // a hit answers one cycle after the request without apb traffic
                    assert (!psel_seen && hit_seen && cycles == 2) else begin
                        $display("test %s: expected a single-cycle TLB hit", name);
                        n_errors++;
                    end
                    compare_field(name, "dtlb_miss_o pulses", 34'(misses), 34'd0);
                end
                if (n_errors == errors_before) begin
                    $display("test %-24s ok", name);
                end else begin
                    $display("test %-24s failed", name);
                    n_failed++;
                end
            end
        end
    endtask

    initial begin
        rst_n          = 1'b0;
        translation_on = 1'b0;
        flush          = 1'b0;
        lsu_req        = 1'b0;
        lsu_req_data   = '0;
        priv_lvl       = mmu_pkg::PRIV_LVL_S;
        sum            = 1'b0;
        mxr            = 1'b0;
        satp_ppn       = ROOT_PPN;
        fill_tables();
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);

        // bare mode
        set_mode(1'b0, mmu_pkg::PRIV_LVL_S, 1'b0, 1'b0);
        run_access("bare load", 32'hdead_beef, 1'b0, 1'b0, {2'b00, 32'hdead_beef}, WALK_NO);
        run_access("bare store", 32'h8000_0004, 1'b1, 1'b0, {2'b00, 32'h8000_0004}, WALK_NO);

        // 4 KiB page refill then hit
        set_mode(1'b1, mmu_pkg::PRIV_LVL_S, 1'b0, 1'b0);
        run_access("4k load miss", 32'h0040_0abc, 1'b0, 1'b0, {22'h12345, 12'habc}, WALK_YES);
        run_access("4k load hit", 32'h0040_0123, 1'b0, 1'b0, {22'h12345, 12'h123}, WALK_NO);
        run_access("4k store hit", 32'h0040_0010, 1'b1, 1'b0, {22'h12345, 12'h010}, WALK_NO);

        // megapages
        run_access("4m load", 32'h0093_4567, 1'b0, 1'b0, {12'h001, 22'h13_4567}, WALK_YES);
        run_access("4m misaligned", 32'h00c0_0010, 1'b0, 1'b1, '0, WALK_YES);

        // permission faults
        run_access("store w clear", 32'h0040_1000, 1'b1, 1'b1, '0, WALK_ANY);
        run_access("store d clear", 32'h0040_2008, 1'b1, 1'b1, '0, WALK_ANY);
        set_mode(1'b1, mmu_pkg::PRIV_LVL_U, 1'b0, 1'b0);
        run_access("u load of s page", 32'h0040_0004, 1'b0, 1'b1, '0, WALK_ANY);
        set_mode(1'b1, mmu_pkg::PRIV_LVL_S, 1'b0, 1'b0);
        run_access("s load u page", 32'h0040_3000, 1'b0, 1'b1, '0, WALK_ANY);
        set_mode(1'b1, mmu_pkg::PRIV_LVL_S, 1'b1, 1'b0);
        run_access("s load u page sum", 32'h0040_3040, 1'b0, 1'b0, {22'h23456, 12'h040},
                   WALK_ANY);
        set_mode(1'b1, mmu_pkg::PRIV_LVL_S, 1'b0, 1'b0);
        run_access("exec only mxr off", 32'h0040_4000, 1'b0, 1'b1, '0, WALK_ANY);
        set_mode(1'b1, mmu_pkg::PRIV_LVL_S, 1'b0, 1'b1);
        run_access("exec only mxr on", 32'h0040_4100, 1'b0, 1'b0, {22'h12348, 12'h100},
                   WALK_ANY);

        // invalid level-0 ptes
        set_mode(1'b1, mmu_pkg::PRIV_LVL_S, 1'b0, 1'b0);
        run_access("pte v clear load", 32'h0040_5000, 1'b0, 1'b1, '0, WALK_YES);
        run_access("pte v clear store", 32'h0040_5004, 1'b1, 1'b1, '0, WALK_YES);
        run_access("pte a clear store", 32'h0040_6000, 1'b1, 1'b1, '0, WALK_YES);

        // flush forces a new walk
        run_access("flush warm", 32'h0040_0200, 1'b0, 1'b0, {22'h12345, 12'h200}, WALK_ANY);
        flush_tlb();
        run_access("after flush", 32'h0040_0300, 1'b0, 1'b0, {22'h12345, 12'h300}, WALK_YES);

        // three pages through two entries
        for (int r = 0; r < 2; r++) begin
            run_access("three pages a", 32'h0040_7010, 1'b0, 1'b0, {22'h3aaaa, 12'h010},
                       WALK_ANY);
            run_access("three pages b", 32'h0040_8020, 1'b0, 1'b0, {22'h3bbbb, 12'h020},
                       WALK_ANY);
            run_access("three pages c", 32'h0040_0030, 1'b0, 1'b0, {22'h12345, 12'h030},
                       WALK_ANY);
        end

        repeat (2) @(posedge clk);
        $display("tests %0d, failed %0d, check errors %0d, bound assertion failures %0d",
                 n_tests, n_failed, n_errors, u_mmu_sv32.u_mmu_props.fail_cnt);
        if (n_failed == 0 && n_errors == 0 && !timed_out &&
            u_mmu_sv32.u_mmu_props.fail_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
common/mmu_pkg.sv
dtlb/dtlb.sv
ptw/ptw.sv
logic/lsu_translate.sv
logic/mmu_sv32.sv
testbench/mmu_props.sv
testbench/tb_mmu.sv
